// ==== ex_pkg.sv ====
// execute stage shared types
`default_nettype none

package ex_pkg;

    parameter int XLEN = 64;
    parameter int WLEN = 32;
    parameter int DEF_WB_CREDITS = 4;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [WLEN-1:0] word_t;   // pc and word operands
    typedef logic [4:0]      reg_idx_t;
    typedef logic [31:0]     imm_t;    // sign-extended and placed by decode

    typedef enum logic [4:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
        MUL, MULH, MULHSU, MULHU,
        DIV, DIVU, REM, REMU,
        LUI, AUIPC, JAL, JALR,
        BEQ, BNE, BLT, BGE, BLTU, BGEU,
        LOAD, STORE
    } alu_op_e;

    typedef enum logic [1:0] {
        IDLE,
        DIVIDE,
        FLUSHED
    } ctrl_state_e;

    typedef struct packed {
        alu_op_e  op;
        logic     is_word;
        logic     use_imm;
        reg_idx_t rd;
        word_t    pc;
        imm_t     imm;
        xlen_t    rs1_val;
        xlen_t    rs2_val;
    } ex_issue_t;

    typedef struct packed {
        reg_idx_t rd;          // zero when nothing is written
        xlen_t    value;
        xlen_t    mem_addr;
        logic     is_store;
        logic     is_jump;
        word_t    jump_target;
    } ex_result_t;

    typedef struct packed {
        xlen_t dividend;
        xlen_t divisor;
        logic  is_signed;
        logic  want_rem;
        logic  is_word;
    } div_req_t;

endpackage

`default_nettype wire

// ==== ex_alu.sv ====
// single-cycle execute datapath
`default_nettype none

module ex_alu (
    input  wire ex_pkg::ex_issue_t  i_issue,
    output ex_pkg::ex_result_t      o_result,
    output logic                    o_is_div,
    output ex_pkg::div_req_t        o_div_req
);
    import ex_pkg::*;

    xlen_t               op_a;
    xlen_t               op_b;
    xlen_t               imm_ext;
    xlen_t               pc_ext;
    xlen_t               sum;
    xlen_t               diff;
    xlen_t               addr;
    xlen_t               sll_res;
    xlen_t               srl_res;
    xlen_t               sra_res;
    word_t               sll_w;
    word_t               srl_w;
    word_t               sra_w;
    logic                a_signed;
    logic                b_signed;
    logic signed [129:0] product;
    logic                lt;
    logic                ltu;
    logic                br_eq;
    logic                br_lt;
    logic                br_ltu;
    logic                taken;
    xlen_t               alu_val;

    function automatic xlen_t sext_w(input word_t w);
        return {{32{w[31]}}, w};
    endfunction

    assign imm_ext = {{32{i_issue.imm[31]}}, i_issue.imm};
    assign pc_ext  = {32'b0, i_issue.pc};
    assign op_a    = i_issue.rs1_val;
    assign op_b    = i_issue.use_imm ? imm_ext : i_issue.rs2_val;
    assign addr    = i_issue.rs1_val + imm_ext;

    assign sum     = op_a + op_b;
    assign diff    = op_a - op_b;
    assign sll_res = op_a << op_b[5:0];
    assign srl_res = op_a >> op_b[5:0];
    assign sra_res = $signed(op_a) >>> op_b[5:0];
    assign sll_w   = op_a[31:0] << op_b[4:0];   // word shifts use 5 bits
    assign srl_w   = op_a[31:0] >> op_b[4:0];
    assign sra_w   = $signed(op_a[31:0]) >>> op_b[4:0];
    assign lt      = $signed(op_a) < $signed(op_b);
    assign ltu     = op_a < op_b;

    // one 65x65 signed multiplier covers all four variants
    assign a_signed = (i_issue.op == MULH) || (i_issue.op == MULHSU);
    assign b_signed = (i_issue.op == MULH);
    assign product  = $signed({a_signed & op_a[63], op_a}) * $signed({b_signed & op_b[63], op_b});

    // branches always compare the two registers
    assign br_eq  = i_issue.rs1_val == i_issue.rs2_val;
    assign br_lt  = $signed(i_issue.rs1_val) < $signed(i_issue.rs2_val);
    assign br_ltu = i_issue.rs1_val < i_issue.rs2_val;

    always_comb begin
        case (i_issue.op)
            BEQ:     taken = br_eq;
            BNE:     taken = !br_eq;
            BLT:     taken = br_lt;
            BGE:     taken = !br_lt;
            BLTU:    taken = br_ltu;
            BGEU:    taken = !br_ltu;
            default: taken = 1'b0;
        endcase
    end

    always_comb begin
        o_result    = '0;
        o_result.rd = i_issue.rd;
        o_is_div    = 1'b0;
        alu_val     = '0;
        case (i_issue.op)
            ADD:    alu_val = i_issue.is_word ? sext_w(sum[31:0]) : sum;
            SUB:    alu_val = i_issue.is_word ? sext_w(diff[31:0]) : diff;
            SLL:    alu_val = i_issue.is_word ? sext_w(sll_w) : sll_res;
            SRL:    alu_val = i_issue.is_word ? sext_w(srl_w) : srl_res;
            SRA:    alu_val = i_issue.is_word ? sext_w(sra_w) : sra_res;
            SLT:    alu_val = {63'b0, lt};
            SLTU:   alu_val = {63'b0, ltu};
            XOR:    alu_val = op_a ^ op_b;
            OR:     alu_val = op_a | op_b;
            AND:    alu_val = op_a & op_b;
            MUL:    alu_val = i_issue.is_word ? sext_w(product[31:0]) : product[63:0];
            MULH, MULHSU, MULHU: alu_val = product[127:64];
            DIV, DIVU, REM, REMU: o_is_div = 1'b1;   // result comes from the divider
            LUI:    alu_val = imm_ext;
            AUIPC:  alu_val = pc_ext + imm_ext;
            JAL: begin
                alu_val              = pc_ext + 64'd4;
                o_result.is_jump     = 1'b1;
                o_result.jump_target = i_issue.pc + i_issue.imm;
            end
            JALR: begin
                alu_val              = pc_ext + 64'd4;
                o_result.is_jump     = 1'b1;
                o_result.jump_target = {addr[31:1], 1'b0};
            end
            BEQ, BNE, BLT, BGE, BLTU, BGEU: begin
                o_result.rd      = '0;
                o_result.is_jump = taken;
                if (taken) begin
                    o_result.jump_target = i_issue.pc + i_issue.imm;
                end
            end
            LOAD:   o_result.mem_addr = addr;   // data returns from memory later
            STORE: begin
                o_result.rd       = '0;
                o_result.is_store = 1'b1;
                o_result.mem_addr = addr;
                alu_val           = i_issue.rs2_val;
            end
            default: alu_val = '0;
        endcase
        o_result.value = alu_val;
    end

    always_comb begin
        o_div_req.dividend  = i_issue.rs1_val;
        o_div_req.divisor   = i_issue.rs2_val;
        o_div_req.is_signed = (i_issue.op == DIV) || (i_issue.op == REM);
        o_div_req.want_rem  = (i_issue.op == REM) || (i_issue.op == REMU);
        o_div_req.is_word   = i_issue.is_word;
    end

endmodule

`default_nettype wire

// ==== ex_divider.sv ====
// radix-2 restoring divider
`default_nettype none

module ex_divider (
    input  wire                   clk,
    input  wire                   reset,
    input  wire                   i_start,
    input  wire                   i_abort,
    input  wire ex_pkg::div_req_t i_req,
    output logic                  o_done,
    output logic                  o_busy,
    output ex_pkg::xlen_t         o_result
);
    import ex_pkg::*;

    xlen_t       dvd_src;
    xlen_t       dvs_src;
    logic        dvd_neg;
    logic        dvs_neg;
    xlen_t       dvd_mag;
    xlen_t       dvs_mag;

    logic        busy;
    logic [6:0]  count;        // bits still to process
    xlen_t       rem_q;
    xlen_t       quo_q;
    xlen_t       dvs_q;
    xlen_t       dvd_q;
    logic        neg_quo_q;
    logic        neg_rem_q;
    logic        want_rem_q;
    logic        is_word_q;
    logic        div_zero_q;

    logic [64:0] rem_shift;
    logic [64:0] trial;
    xlen_t       quo_fix;
    xlen_t       rem_fix;
    xlen_t       res_raw;

    // word operands widened from the low half
    assign dvd_src = i_req.is_word ?
        {{32{i_req.is_signed & i_req.dividend[31]}}, i_req.dividend[31:0]} : i_req.dividend;
    assign dvs_src = i_req.is_word ?
        {{32{i_req.is_signed & i_req.divisor[31]}}, i_req.divisor[31:0]} : i_req.divisor;
    assign dvd_neg = i_req.is_signed & dvd_src[63];
    assign dvs_neg = i_req.is_signed & dvs_src[63];
    assign dvd_mag = dvd_neg ? -dvd_src : dvd_src;
    assign dvs_mag = dvs_neg ? -dvs_src : dvs_src;

    always_ff @(posedge clk) begin
        if (reset || i_abort) begin
            busy  <= 1'b0;
            count <= '0;
        end else if (i_start) begin
            busy  <= 1'b1;
            count <= i_req.is_word ? 7'd32 : 7'd64;
        end else if (busy) begin
            if (count != '0) begin
                count <= count - 7'd1;
            end else begin
                busy <= 1'b0;   // finish cycle
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_start) begin
            rem_q      <= '0;
            quo_q      <= i_req.is_word ? {dvd_mag[31:0], 32'b0} : dvd_mag;
            dvs_q      <= dvs_mag;
            dvd_q      <= dvd_src;
            neg_quo_q  <= dvd_neg ^ dvs_neg;
            neg_rem_q  <= dvd_neg;
            want_rem_q <= i_req.want_rem;
            is_word_q  <= i_req.is_word;
            div_zero_q <= (dvs_src == '0);
        end else if (busy && count != '0) begin
            quo_q <= {quo_q[62:0], !trial[64]};
            rem_q <= trial[64] ? rem_shift[63:0] : trial[63:0];
        end
    end

    assign rem_shift = {rem_q, quo_q[63]};
    assign trial     = rem_shift - {1'b0, dvs_q};

    // most negative by -1 needs no special case, the magnitude path yields the dividend
    assign quo_fix = neg_quo_q ? -quo_q : quo_q;
    assign rem_fix = neg_rem_q ? -rem_q : rem_q;

    always_comb begin
        if (div_zero_q) begin
            res_raw = want_rem_q ? dvd_q : '1;
        end else begin
            res_raw = want_rem_q ? rem_fix : quo_fix;
        end
    end

    assign o_result = is_word_q ? {{32{res_raw[31]}}, res_raw[31:0]} : res_raw;
    assign o_done   = busy && (count == '0);
    assign o_busy   = busy;

    a_no_start_busy: assert property (@(posedge clk) disable iff (reset) !(i_start && o_busy))
        else $error("divider started while busy");

endmodule

`default_nettype wire

// ==== ex_credit_counter.sv ====
// writeback credit pool
`default_nettype none

module ex_credit_counter #(
    parameter int CREDITS = 4
) (
    input  wire  clk,
    input  wire  reset,
    input  wire  i_spend,
    input  wire  i_return,
    output logic o_has_credit
);
    localparam int CW = $clog2(CREDITS + 1);

    logic [CW-1:0] count;

    always_ff @(posedge clk) begin
        if (reset) begin
            count <= CW'(CREDITS);
        end else if (i_spend && !i_return) begin
            count <= count - 1'b1;
        end else if (i_return && !i_spend) begin
            count <= count + 1'b1;
        end
    end

    // credit left once this cycle's spend and return settle
    assign o_has_credit = (count > CW'(i_spend)) || i_return;

    a_no_spend_empty: assert property (@(posedge clk) disable iff (reset)
        !(i_spend && count == '0)) else $error("credit spent with none left");
    a_no_return_full: assert property (@(posedge clk) disable iff (reset)
        !(i_return && count == CW'(CREDITS))) else $error("credit returned while pool full");

endmodule

`default_nettype wire

// ==== ex_ctrl_fsm.sv ====
// execute stage sequencer
`default_nettype none

module ex_ctrl_fsm (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     i_issue_valid,
    input  wire                     i_flush,
    input  wire                     i_has_credit,
    input  wire                     i_is_div,
    input  wire ex_pkg::ex_result_t i_alu_result,
    input  wire                     i_div_done,
    input  wire ex_pkg::xlen_t      i_div_result,
    input  wire ex_pkg::reg_idx_t   i_rd,
    output logic                    o_issue_ready,
    output logic                    o_div_start,
    output logic                    o_div_abort,
    output logic                    o_spend,
    output logic                    o_wb_valid,
    output ex_pkg::ex_result_t      o_wb
);
    import ex_pkg::*;

    ctrl_state_e state;
    ctrl_state_e state_next;
    reg_idx_t    div_rd;       // destination held across the divide
    ex_result_t  div_wb;
    logic        accept;
    logic        emit;

    assign o_issue_ready = (state == IDLE) && i_has_credit;
    assign accept        = i_issue_valid && o_issue_ready;
    assign o_div_start   = accept && i_is_div && !i_flush;
    assign o_div_abort   = i_flush;
    assign o_spend       = o_wb_valid;

    // flush drops whatever would be registered this cycle
    assign emit = !i_flush && ((accept && !i_is_div) || (state == DIVIDE && i_div_done));

    always_comb begin
        div_wb       = '0;
        div_wb.rd    = div_rd;
        div_wb.value = i_div_result;
    end

    always_comb begin
        state_next = state;
        if (i_flush) begin
            state_next = FLUSHED;
        end else begin
            case (state)
                IDLE:    if (o_div_start) state_next = DIVIDE;
                DIVIDE:  if (i_div_done) state_next = IDLE;
                default: state_next = IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= IDLE;
            o_wb_valid <= 1'b0;
        end else begin
            state      <= state_next;
            o_wb_valid <= emit;
        end
    end

    always_ff @(posedge clk) begin
        if (o_div_start) begin
            div_rd <= i_rd;
        end
        if (emit) begin
            o_wb <= (state == DIVIDE) ? div_wb : i_alu_result;
        end
    end

    // a result is only registered when the pool still covers it
    a_wb_with_credit: assert property (@(posedge clk) disable iff (reset)
        o_wb_valid |-> $past(i_has_credit)) else $error("writeback without credit");

endmodule

`default_nettype wire

// ==== ex_unit.sv ====
// RV64IM execute stage top
`default_nettype none

module ex_unit #(
    parameter int WB_CREDITS = ex_pkg::DEF_WB_CREDITS
) (
    input  wire                    clk,
    input  wire                    reset,
    input  wire                    i_issue_valid,
    input  wire ex_pkg::ex_issue_t i_issue,
    input  wire                    i_flush,
    input  wire                    i_credit_return,
    output logic                   o_issue_ready,
    output logic                   o_wb_valid,
    output ex_pkg::ex_result_t     o_wb
);
    import ex_pkg::*;

    ex_result_t alu_result;
    logic       is_div;
    div_req_t   div_req;
    logic       div_start;
    logic       div_abort;
    logic       div_done;
    xlen_t      div_result;
    logic       spend;
    logic       has_credit;

    ex_alu u_alu (
        .i_issue   (i_issue),
        .o_result  (alu_result),
        .o_is_div  (is_div),
        .o_div_req (div_req)
    );

    // request comes straight from the alu, start is same cycle
    ex_divider u_divider (
        .clk      (clk),
        .reset    (reset),
        .i_start  (div_start),
        .i_abort  (div_abort),
        .i_req    (div_req),
        .o_done   (div_done),
        .o_busy   (),
        .o_result (div_result)
    );

    ex_credit_counter #(
        .CREDITS (WB_CREDITS)
    ) u_credits (
        .clk          (clk),
        .reset        (reset),
        .i_spend      (spend),
        .i_return     (i_credit_return),
        .o_has_credit (has_credit)
    );

    ex_ctrl_fsm u_ctrl (
        .clk           (clk),
        .reset         (reset),
        .i_issue_valid (i_issue_valid),
        .i_flush       (i_flush),
        .i_has_credit  (has_credit),
        .i_is_div      (is_div),
        .i_alu_result  (alu_result),
        .i_div_done    (div_done),
        .i_div_result  (div_result),
        .i_rd          (i_issue.rd),
        .o_issue_ready (o_issue_ready),
        .o_div_start   (div_start),
        .o_div_abort   (div_abort),
        .o_spend       (spend),
        .o_wb_valid    (o_wb_valid),
        .o_wb          (o_wb)
    );

endmodule

`default_nettype wire

// ==== tb_ex_unit.sv ====
// execute stage testbench
`default_nettype none

module tb_ex_unit;
    import ex_pkg::*;

    localparam int WB_CREDITS   = 4;
    localparam int RESET_CYCLES = 16;
    localparam int DIV_OPS      = 25;
    localparam int ALU_OPS      = 100;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + DIV_OPS * 70 + ALU_OPS * 8 + 500;

    logic       clk = 1'b0;
    logic       reset = 1'b1;
    logic       i_issue_valid = 1'b0;
    ex_issue_t  i_issue = '0;
    logic       i_flush = 1'b0;
    logic       i_credit_return = 1'b0;
    logic       o_issue_ready;
    logic       o_wb_valid;
    ex_result_t o_wb;

    ex_result_t exp_q[$];
    logic [31:0] lcg_state = 32'h7443336f;
    int         errors = 0;
    int         passes = 0;
    int         wb_count = 0;
    int         owed = 0;          // credits spent and not yet returned
    int         ret_delay = 2;
    int         ret_wait = 0;
    logic       hold_returns = 1'b0;
    int         cycles = 0;

    ex_unit #(.WB_CREDITS(WB_CREDITS)) UUT (
        .clk(clk), .reset(reset), .i_issue_valid(i_issue_valid), .i_issue(i_issue),
        .i_flush(i_flush), .i_credit_return(i_credit_return),
        .o_issue_ready(o_issue_ready), .o_wb_valid(o_wb_valid), .o_wb(o_wb)
    );

    always #4 clk = !clk;

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic xlen_t rand64();
        xlen_t v;
        v[63:32] = lcg_next();
        v[31:0]  = lcg_next();
        return v;
    endfunction

    function automatic xlen_t sx32(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    function automatic xlen_t div_expect(input xlen_t a, input xlen_t b, input logic sgn,
                                         input logic rem, input logic w);
        xlen_t x;
        xlen_t y;
        xlen_t q;
        xlen_t r;
        x = w ? (sgn ? sx32(a[31:0]) : {32'b0, a[31:0]}) : a;
        y = w ? (sgn ? sx32(b[31:0]) : {32'b0, b[31:0]}) : b;
        if (y == 0) begin
            q = '1;
            r = x;
        end else if (sgn && x == {1'b1, 63'b0} && y == '1) begin
            q = x;     // signed overflow
            r = 0;
        end else if (sgn) begin
            q = $signed(x) / $signed(y);
            r = $signed(x) % $signed(y);
        end else begin
            q = x / y;
            r = x % y;
        end
        q = rem ? r : q;
        return w ? sx32(q[31:0]) : q;
    endfunction

    // reference model built from the operation rules
    function automatic ex_result_t expect_result(input ex_issue_t t);
        ex_result_t r;
        xlen_t a;
        xlen_t b;
        xlen_t imm;
        xlen_t sra64;
        logic signed [127:0] pa;
        logic signed [127:0] pb;
        logic signed [127:0] p;
        logic signed [31:0] a32;
        logic taken;
        r   = '0;
        r.rd = t.rd;
        imm = sx32(t.imm);
        a   = t.rs1_val;
        b   = t.use_imm ? imm : t.rs2_val;
        a32 = a[31:0];
        sra64 = $signed(a) >>> b[5:0];
        pa  = (t.op == MULHU) ? {64'b0, a} : {{64{a[63]}}, a};
        pb  = (t.op == MULH) ? {{64{b[63]}}, b} : {64'b0, b};
        p   = pa * pb;
        taken = 1'b0;
        case (t.op)
            ADD:    r.value = t.is_word ? sx32(a[31:0] + b[31:0]) : a + b;
            SUB:    r.value = t.is_word ? sx32(a[31:0] - b[31:0]) : a - b;
            SLL:    r.value = t.is_word ? sx32(a[31:0] << b[4:0]) : a << b[5:0];
            SRL:    r.value = t.is_word ? sx32(a[31:0] >> b[4:0]) : a >> b[5:0];
            SRA:    r.value = t.is_word ? sx32(a32 >>> b[4:0]) : sra64;
            SLT:    r.value = ($signed(a) < $signed(b)) ? 64'd1 : 64'd0;
            SLTU:   r.value = (a < b) ? 64'd1 : 64'd0;
            XOR:    r.value = a ^ b;
            OR:     r.value = a | b;
            AND:    r.value = a & b;
            MUL:    r.value = t.is_word ? sx32(a[31:0] * b[31:0]) : a * b;
            MULH, MULHSU, MULHU: r.value = p[127:64];
            DIV, DIVU, REM, REMU: r.value = div_expect(t.rs1_val, t.rs2_val,
                (t.op == DIV || t.op == REM), (t.op == REM || t.op == REMU), t.is_word);
            LUI:    r.value = imm;
            AUIPC:  r.value = {32'b0, t.pc} + imm;
            JAL, JALR: begin
                r.value       = {32'b0, t.pc} + 64'd4;
                r.is_jump     = 1'b1;
                r.jump_target = (t.op == JAL) ? t.pc + t.imm : (t.rs1_val[31:0] + t.imm) & ~32'd1;
            end
            LOAD:   r.mem_addr = t.rs1_val + imm;
            STORE: begin
                r.rd       = '0;
                r.is_store = 1'b1;
                r.mem_addr = t.rs1_val + imm;
                r.value    = t.rs2_val;
            end
            default: begin
                case (t.op)
                    BEQ:  taken = t.rs1_val == t.rs2_val;
                    BNE:  taken = t.rs1_val != t.rs2_val;
                    BLT:  taken = $signed(t.rs1_val) < $signed(t.rs2_val);
                    BGE:  taken = $signed(t.rs1_val) >= $signed(t.rs2_val);
                    BLTU: taken = t.rs1_val < t.rs2_val;
                    default: taken = t.rs1_val >= t.rs2_val;
                endcase
                r.rd          = '0;
                r.is_jump     = taken;
                r.jump_target = taken ? t.pc + t.imm : '0;
            end
        endcase
        return r;
    endfunction

    function automatic ex_issue_t make_issue(input alu_op_e op, input logic w, input logic ui);
        ex_issue_t t;
        t.op      = op;
        t.is_word = w;
        t.use_imm = ui;
        t.rd      = 5'(lcg_next() % 31 + 1);
        t.pc      = lcg_next() & ~32'd3;
        t.imm     = lcg_next();
        t.rs1_val = rand64();
        t.rs2_val = rand64();
        return t;
    endfunction

    task automatic check_result(input ex_result_t got, input ex_result_t exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t o_wb: got %h expected %h", $time, got, exp);
        end else begin
            passes++;
        end
    endtask

    task automatic check_credit_use(input int used, input string where);
        if (used > WB_CREDITS) begin
            errors++;
            $display("credit limit broken at %0t in %s: %0d results without return, limit %0d",
                     $time, where, used, WB_CREDITS);
        end else begin
            passes++;
        end
    endtask

    // caller sits on a rising edge, returns on the edge of the transfer
    task automatic issue_op(input ex_issue_t t, input bit expect_it);
        i_issue_valid <= 1'b1;
        i_issue       <= t;
        @(negedge clk);
        while (!o_issue_ready) @(negedge clk);
        if (expect_it) exp_q.push_back(expect_result(t));
        @(posedge clk);
    endtask

    task automatic finish_issue();
        i_issue_valid <= 1'b0;
        @(negedge clk);
        while (exp_q.size() != 0) @(negedge clk);
        @(posedge clk);
    endtask

    task automatic report(input string name, input int err0);
        $display("test %s finished with %0d errors", name, errors - err0);
    endtask

    task automatic test_alu_random();
        alu_op_e ops[14] = '{ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND,
                             MUL, MULH, MULHSU, MULHU};
        int err0;
        logic w;
        err0 = errors;
        for (int rep = 0; rep < 2; rep++) begin
            foreach (ops[i]) begin
                issue_op(make_issue(ops[i], 1'b0, lcg_next() % 2 == 0), 1'b1);
                w = (ops[i] inside {ADD, SUB, SLL, SRL, SRA, MUL});
                if (w) issue_op(make_issue(ops[i], 1'b1, lcg_next() % 2 == 0), 1'b1);
            end
        end
        issue_op(make_issue(LUI, 1'b0, 1'b1), 1'b1);
        issue_op(make_issue(AUIPC, 1'b0, 1'b1), 1'b1);
        finish_issue();
        report("alu_random", err0);
    endtask

    task automatic test_branch_jump();
        alu_op_e br[6] = '{BEQ, BNE, BLT, BGE, BLTU, BGEU};
        ex_issue_t t;
        int err0;
        err0 = errors;
        foreach (br[i]) begin
            t = make_issue(br[i], 1'b0, 1'b0);
            issue_op(t, 1'b1);
            t.rs2_val = t.rs1_val;     // equal operands
            issue_op(t, 1'b1);
        end
        issue_op(make_issue(JAL, 1'b0, 1'b1), 1'b1);
        issue_op(make_issue(JALR, 1'b0, 1'b1), 1'b1);
        finish_issue();
        report("branch_jump", err0);
    endtask

    task automatic test_load_store();
        int err0;
        err0 = errors;
        for (int i = 0; i < 3; i++) begin
            issue_op(make_issue(LOAD, 1'b0, 1'b1), 1'b1);
            issue_op(make_issue(STORE, 1'b0, 1'b1), 1'b1);
        end
        finish_issue();
        report("load_store", err0);
    endtask

    task automatic test_divide();
        alu_op_e dops[4] = '{DIV, DIVU, REM, REMU};
        ex_issue_t t;
        int err0;
        err0 = errors;
        for (int k = 0; k < 6; k++) begin
            foreach (dops[i]) begin
                t = make_issue(dops[i], k[0], 1'b0);
                if (k == 2 || k == 3) t.rs2_val = 0;         // divide by zero
                if (k >= 4) begin
                    // most negative by -1, 64-bit then word
                    t.rs1_val = k[0] ? 64'h0000_0000_8000_0000 : {1'b1, 63'b0};
                    t.rs2_val = '1;
                end
                issue_op(t, 1'b1);
                issue_op(make_issue(ADD, 1'b0, 1'b0), 1'b1);
            end
        end
        finish_issue();
        report("divide", err0);
    endtask

    task automatic test_backpressure();
        int err0;
        int wb0;
        err0 = errors;
        @(negedge clk);
        while (owed != 0) @(negedge clk);
        hold_returns = 1'b1;
        wb0 = wb_count;
        @(posedge clk);
        fork
            begin
                for (int i = 0; i < 8; i++) issue_op(make_issue(XOR, 1'b0, 1'b0), 1'b1);
                finish_issue();
            end
            begin
                repeat (20) @(negedge clk);
                check_credit_use(wb_count - wb0, "held returns");
                if (wb_count - wb0 != WB_CREDITS) begin
                    errors++;
                    $display("expected %0d results while credits were held, saw %0d",
                             WB_CREDITS, wb_count - wb0);
                end
                hold_returns = 1'b0;
            end
        join
        if (wb_count - wb0 != 8) begin
            errors++;
            $display("back-pressure stream lost results: %0d of 8 arrived", wb_count - wb0);
        end
        report("backpressure", err0);
    endtask

    task automatic test_flush_divide();
        int err0;
        err0 = errors;
        issue_op(make_issue(DIVU, 1'b0, 1'b0), 1'b0);
        i_issue_valid <= 1'b0;
        repeat (5) @(posedge clk);
        i_flush <= 1'b1;
        @(posedge clk);
        i_flush <= 1'b0;
        issue_op(make_issue(SUB, 1'b0, 1'b1), 1'b1);
        finish_issue();
        repeat (80) @(posedge clk);   // long enough for a stray divide result
        report("flush_divide", err0);
    endtask

    // result monitor and credit bookkeeping
    always @(posedge clk) begin
        if (!reset && o_wb_valid) begin
            wb_count <= wb_count + 1;
            check_credit_use(owed + 1, "writeback");
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected writeback at %0t with no operation outstanding", $time);
            end else begin
                check_result(o_wb, exp_q.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        int owed_n;
        owed_n = owed + (o_wb_valid ? 1 : 0) - (i_credit_return ? 1 : 0);
        if (reset) begin
            owed            <= 0;
            ret_wait        <= 0;
            i_credit_return <= 1'b0;
        end else begin
            owed <= owed_n;
            if (!hold_returns && owed_n > 0 && ret_wait == 0 && !i_credit_return) begin
                i_credit_return <= 1'b1;
                ret_wait        <= ret_delay;
            end else begin
                i_credit_return <= 1'b0;
                if (ret_wait != 0) ret_wait <= ret_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout after %0d cycles, the DUT stopped responding", CYCLE_LIMIT);
            $display("tests failed");
            $finish;
        end
    end

    initial begin
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        test_alu_random();
        test_branch_jump();
        test_load_store();
        test_divide();
        test_backpressure();
        test_flush_divide();
        $display("checks passed %0d, failed %0d", passes, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
ex_pkg.sv
ex_alu.sv
ex_divider.sv
ex_credit_counter.sv
ex_ctrl_fsm.sv
ex_unit.sv
tb_ex_unit.sv

// ==== run_sim.sh ====
#!/bin/bash
# build and run the execute stage testbench with Verilator

rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_unit \
    -f project.f -o sim_ex \
    && ./obj_dir/sim_ex > sim.log 2>&1 \
    || { echo "build or run error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -q "all tests passed" sim.log && echo "RESULT: PASS" || { echo "RESULT: FAIL"; exit 1; }
